//--- build.f
+incdir+common
common/radio_rx_pkg.sv
src/rx_sync_fifo.sv
rx_ctrl/radio_rx_regs.sv
rx_acq/radio_rx_fsm.sv
src/radio_rx_core.sv
verif/radio_rx_tb.sv

//--- common/radio_rx_macros.svh
// Widths, register map, command codes and FIFO sizing for the receive core
`ifndef RADIO_RX_MACROS_SVH
`define RADIO_RX_MACROS_SVH

// Datapath widths
`define RX_SAMP_W       32
`define RX_TIME_W       64
`define RX_NUM_WORDS_W  64

// Command word layout and codes
`define RX_CMD_W          2
`define RX_CMD_TIMED_POS  31
`define RX_CMD_STOP       2'd0
`define RX_CMD_FINITE     2'd1
`define RX_CMD_CONTINUOUS 2'd2

// Control port register map, byte offsets
`define RX_REG_CMD               20'h00
`define RX_REG_NUM_WORDS_LO      20'h04
`define RX_REG_NUM_WORDS_HI      20'h08
`define RX_REG_TIME_LO           20'h0C
`define RX_REG_TIME_HI           20'h10
`define RX_REG_MAX_WORDS_PER_PKT 20'h14
`define RX_REG_HAS_TIME          20'h18
`define RX_REG_STATUS            20'h1C

// FIFO sizing, overflow margin and reset packet length
`define RX_CMD_FIFO_LOG2  4
`define RX_OUT_FIFO_LOG2  5
`define RX_ALMOST_FULL    5
`define RX_MAX_PKT_RESET  32'd64

// Control port widths
`define RX_ADDR_W 20
`define RX_DATA_W 32

`endif

//--- common/radio_rx_pkg.sv
// Shared struct types of the receive core
// Control request and response, queued command and output stream beat
package radio_rx_pkg;

  `include "radio_rx_macros.svh"

  // ------------------------------
  // Control port
  // ------------------------------

  // Single-cycle write or read request
  typedef struct packed {
    logic                  wr;
    logic                  rd;
    logic [`RX_ADDR_W-1:0] addr;
    logic [`RX_DATA_W-1:0] data;
  } ctrl_req_t;

  // Ack pulse, read data valid with it
  typedef struct packed {
    logic                  ack;
    logic [`RX_DATA_W-1:0] data;
  } ctrl_resp_t;

  // ------------------------------
  // Command queue and sample stream
  // ------------------------------

  // One entry of the command FIFO
  typedef struct packed {
    logic [`RX_TIME_W-1:0]      cmd_time;
    logic                       timed;
    logic [`RX_NUM_WORDS_W-1:0] num_words;
    logic                       continuous;
  } rx_cmd_t;

  // One beat of the output stream, timestamp is for the whole packet
  typedef struct packed {
    logic                  eob;
    logic [`RX_TIME_W-1:0] timestamp;
    logic                  last;
    logic [`RX_SAMP_W-1:0] data;
  } rx_beat_t;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Compile the receive core testbench with Verilator and run it
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f build.f \
  --top-module radio_rx_tb \
  -o radio_rx_sim

./obj_dir/radio_rx_sim 2>&1 | tee sim.log

# The log decides pass or fail
if grep -q "TB FAILED" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi

echo "Simulation finished without failures"

//--- rx_acq/radio_rx_fsm.sv
// Receiver FSM with time compare, word and packet counters
// Builds stream beats and ends bursts on completion, stop or almost-full
`timescale 1ns/1ps
`include "radio_rx_macros.svh"

module radio_rx_fsm (
  input  logic                       radio_clk,
  input  logic                       radio_rst,
  // Command FIFO head
  input  radio_rx_pkg::rx_cmd_t      i_cmd,
  input  logic                       i_cmd_valid,
  output logic                       o_cmd_pop,
  // Stop handshake
  input  logic                       i_cmd_stop,
  output logic                       o_stop_ack,
  input  logic [`RX_DATA_W-1:0]      i_max_pkt_len,
  // Radio side
  input  logic [`RX_TIME_W-1:0]      i_radio_time,
  input  logic [`RX_SAMP_W-1:0]      i_radio_data,
  input  logic                       i_radio_stb,
  // Output FIFO
  input  logic [`RX_OUT_FIFO_LOG2:0] i_out_space,
  output radio_rx_pkg::rx_beat_t     o_beat,
  output logic                       o_beat_push,
  output logic                       o_rx_running
);

  localparam logic [1:0] ST_IDLE       = 2'd0;
  localparam logic [1:0] ST_TIME_CHECK = 2'd1;
  localparam logic [1:0] ST_RUNNING    = 2'd2;
  localparam logic [1:0] ST_STOP       = 2'd3;

  // Pipeline lead of the compares, so the first word lands on the command time
  localparam logic [`RX_TIME_W-1:0] NOW_LEAD  = 3;
  localparam logic [`RX_TIME_W-1:0] PAST_LEAD = 1;
  localparam logic [`RX_OUT_FIFO_LOG2:0] AF_LEVEL = `RX_ALMOST_FULL;

  logic [1:0]                 state;
  logic [`RX_NUM_WORDS_W-1:0] words_left;
  logic [`RX_DATA_W-1:0]      words_left_pkt;
  // Next word opens a packet
  logic                       first_word;
  logic [`RX_TIME_W-1:0]      pkt_time;
  logic [`RX_TIME_W-1:0]      radio_time_d1;
  logic                       time_now;
  logic                       time_past;
  logic                       almost_full;

  assign o_cmd_pop    = (state == ST_STOP);
  assign o_stop_ack   = (state == ST_STOP);
  assign o_rx_running = (state == ST_RUNNING);

  // ------------------------------
  // Time compares
  // ------------------------------
  // Registered to keep the 64-bit compare off the FSM path
  always_ff @(posedge radio_clk) begin
    if (i_radio_stb) begin
      radio_time_d1 <= i_radio_time;
      time_now      <= (radio_time_d1 + NOW_LEAD == i_cmd.cmd_time);
      time_past     <= (radio_time_d1 + PAST_LEAD >= i_cmd.cmd_time);
    end
  end

  // Output FIFO close to overflow
  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      almost_full <= 1'b0;
    end else begin
      almost_full <= (i_out_space < AF_LEVEL);
    end
  end

  // ------------------------------
  // State machine
  // ------------------------------
  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      state       <= ST_IDLE;
      o_beat_push <= 1'b0;
      first_word  <= 1'b1;
    end else begin
      o_beat_push <= 1'b0;
      o_beat.last <= 1'b0;
      o_beat.eob  <= 1'b0;

      case (state)
        ST_IDLE: begin
          first_word <= 1'b1;
          // Strobe needed so the compares see the new head
          if (i_cmd_valid && i_radio_stb) begin
            state <= ST_TIME_CHECK;
          end else if (i_cmd_stop) begin
            state <= ST_STOP;
          end
        end

        ST_TIME_CHECK: begin
          words_left     <= i_cmd.num_words;
          words_left_pkt <= i_max_pkt_len;
          if (i_cmd_stop) begin
            state <= ST_STOP;
          end else if (i_cmd.timed && time_past && i_radio_stb) begin
            // Late command, dropped without data
            state <= ST_STOP;
          end else if (!i_cmd.timed || (i_radio_stb && time_now)) begin
            state <= ST_RUNNING;
          end
        end

        ST_RUNNING: begin
          if (i_radio_stb) begin
            o_beat_push <= 1'b1;
            o_beat.data <= i_radio_data;
            // Packet stamped with the time of its first word
            if (first_word) begin
              first_word       <= 1'b0;
              pkt_time         <= i_radio_time;
              o_beat.timestamp <= i_radio_time;
            end else begin
              o_beat.timestamp <= pkt_time;
            end

            words_left     <= words_left - 1'b1;
            words_left_pkt <= words_left_pkt - 1'b1;

            if ((words_left == 1 && !i_cmd.continuous) || i_cmd_stop) begin
              // Command done or stopped
              o_beat.last <= 1'b1;
              o_beat.eob  <= 1'b1;
              first_word  <= 1'b1;
              state       <= ST_STOP;
            end else if (words_left_pkt == 1) begin
              // Packet boundary, burst continues
              o_beat.last    <= 1'b1;
              first_word     <= 1'b1;
              words_left_pkt <= i_max_pkt_len;
            end

            // Overrun, close the burst while the FIFO still has room
            if (almost_full) begin
              o_beat.last <= 1'b1;
              o_beat.eob  <= 1'b1;
              first_word  <= 1'b1;
              state       <= ST_STOP;
            end
          end
        end

        // One cycle to ack the stop and pop the command
        ST_STOP: begin
          state <= ST_IDLE;
        end

        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

//--- rx_ctrl/radio_rx_regs.sv
// Control-port register file of the receive core
// Command staging, stop request and status readback
`timescale 1ns/1ps
`include "radio_rx_macros.svh"

module radio_rx_regs (
  input  logic                       radio_clk,
  input  logic                       radio_rst,
  input  radio_rx_pkg::ctrl_req_t    i_ctrl_req,
  output radio_rx_pkg::ctrl_resp_t   o_ctrl_resp,
  // Command FIFO write side
  output radio_rx_pkg::rx_cmd_t      o_cmd,
  output logic                       o_cmd_valid,
  input  logic                       i_cmd_ready,
  input  logic [`RX_CMD_FIFO_LOG2:0] i_cmd_space,
  // Stop handshake with the FSM
  output logic                       o_cmd_stop,
  input  logic                       i_stop_ack,
  output logic                       o_fifo_clear,
  // Static configuration
  output logic [`RX_DATA_W-1:0]      o_max_pkt_len,
  output logic                       o_has_time
);

  logic [`RX_CMD_W-1:0]       cmd_code;
  logic                       cmd_timed;
  logic [`RX_NUM_WORDS_W-1:0] cmd_num_words;
  logic [`RX_TIME_W-1:0]      cmd_time;
  logic                       is_stop;

  // Staged command as it enters the FIFO
  assign o_cmd.cmd_time   = cmd_time;
  assign o_cmd.timed      = cmd_timed;
  assign o_cmd.num_words  = cmd_num_words;
  assign o_cmd.continuous = (cmd_code == `RX_CMD_CONTINUOUS);

  // STOP bypasses the queue
  assign is_stop = (i_ctrl_req.data[`RX_CMD_W-1:0] == `RX_CMD_STOP);

  always_ff @(posedge radio_clk) begin
    if (radio_rst) begin
      o_ctrl_resp.ack <= 1'b0;
      o_cmd_valid     <= 1'b0;
      o_cmd_stop      <= 1'b0;
      o_fifo_clear    <= 1'b0;
      cmd_code        <= `RX_CMD_STOP;
      cmd_timed       <= 1'b0;
      cmd_num_words   <= '0;
      cmd_time        <= '0;
      o_max_pkt_len   <= `RX_MAX_PKT_RESET;
      o_has_time      <= 1'b1;
    end else begin
      o_ctrl_resp.ack  <= 1'b0;
      o_ctrl_resp.data <= '0;
      o_fifo_clear     <= 1'b0;

      // FSM has taken the stop
      if (i_stop_ack) begin
        o_cmd_stop <= 1'b0;
      end

      // Queued command ack once the FIFO accepts it
      if (o_cmd_valid && i_cmd_ready) begin
        o_cmd_valid     <= 1'b0;
        o_ctrl_resp.ack <= 1'b1;
      end

      // ------------------------------
      // Writes
      // ------------------------------
      if (i_ctrl_req.wr) begin
        case (i_ctrl_req.addr)
          `RX_REG_CMD: begin
            cmd_code  <= i_ctrl_req.data[`RX_CMD_W-1:0];
            cmd_timed <= i_ctrl_req.data[`RX_CMD_TIMED_POS];
            if (is_stop) begin
              o_ctrl_resp.ack <= 1'b1;
              o_fifo_clear    <= 1'b1;
            end else begin
              // Ack deferred until the FIFO push
              o_cmd_valid <= 1'b1;
            end
            // Pending stop stays up until acked
            if (!o_cmd_stop || i_stop_ack) begin
              o_cmd_stop <= is_stop;
            end
          end
          `RX_REG_NUM_WORDS_LO:      cmd_num_words[31:0]  <= i_ctrl_req.data;
          `RX_REG_NUM_WORDS_HI:      cmd_num_words[63:32] <= i_ctrl_req.data;
          `RX_REG_TIME_LO:           cmd_time[31:0]       <= i_ctrl_req.data;
          `RX_REG_TIME_HI:           cmd_time[63:32]      <= i_ctrl_req.data;
          `RX_REG_MAX_WORDS_PER_PKT: o_max_pkt_len        <= i_ctrl_req.data;
          `RX_REG_HAS_TIME:          o_has_time           <= i_ctrl_req.data[0];
          default: ;
        endcase
        // Everything except a queued command acks next cycle
        if (i_ctrl_req.addr != `RX_REG_CMD) begin
          o_ctrl_resp.ack <= 1'b1;
        end
      end

      // ------------------------------
      // Reads
      // ------------------------------
      if (i_ctrl_req.rd) begin
        o_ctrl_resp.ack <= 1'b1;
        case (i_ctrl_req.addr)
          `RX_REG_CMD: begin
            o_ctrl_resp.data[`RX_CMD_W-1:0]   <= cmd_code;
            o_ctrl_resp.data[`RX_CMD_TIMED_POS] <= cmd_timed;
          end
          `RX_REG_NUM_WORDS_LO:      o_ctrl_resp.data <= cmd_num_words[31:0];
          `RX_REG_NUM_WORDS_HI:      o_ctrl_resp.data <= cmd_num_words[63:32];
          `RX_REG_TIME_LO:           o_ctrl_resp.data <= cmd_time[31:0];
          `RX_REG_TIME_HI:           o_ctrl_resp.data <= cmd_time[63:32];
          `RX_REG_MAX_WORDS_PER_PKT: o_ctrl_resp.data <= o_max_pkt_len;
          `RX_REG_HAS_TIME:          o_ctrl_resp.data[0] <= o_has_time;
          // Free command FIFO entries
          `RX_REG_STATUS: o_ctrl_resp.data[`RX_CMD_FIFO_LOG2:0] <= i_cmd_space;
          default: ;
        endcase
      end
    end
  end

endmodule

//--- src/radio_rx_core.sv
// Receive core top level
// Registers, command FIFO, receiver FSM and output FIFO
`timescale 1ns/1ps
`include "radio_rx_macros.svh"

module radio_rx_core (
  input  logic                       radio_clk,
  input  logic                       radio_rst,
  // Control port
  input  radio_rx_pkg::ctrl_req_t    i_ctrl_req,
  output radio_rx_pkg::ctrl_resp_t   o_ctrl_resp,
  // Radio side
  input  logic [`RX_TIME_W-1:0]      i_radio_time,
  input  logic [`RX_SAMP_W-1:0]      i_radio_data,
  input  logic                       i_radio_stb,
  output logic                       o_rx_running,
  // Sample stream
  output radio_rx_pkg::rx_beat_t     o_rx_beat,
  output logic                       o_rx_valid,
  input  logic                       i_rx_ready,
  output logic                       o_rx_has_time
);

  // Command path between registers, FIFO and FSM
  radio_rx_pkg::rx_cmd_t       reg_cmd;
  logic                        reg_cmd_valid;
  logic                        cmd_ready;
  logic [`RX_CMD_FIFO_LOG2:0]  cmd_space;
  radio_rx_pkg::rx_cmd_t       head_cmd;
  logic                        head_valid;
  logic                        cmd_pop;
  logic                        cmd_stop;
  logic                        stop_ack;
  logic                        cmd_clear;
  logic [`RX_DATA_W-1:0]       max_pkt_len;

  // Sample path into the output FIFO
  radio_rx_pkg::rx_beat_t      fsm_beat;
  logic                        fsm_push;
  logic [`RX_OUT_FIFO_LOG2:0]  out_space;

  // ------------------------------
  // Registers
  // ------------------------------
  radio_rx_regs regs_i (
    .radio_clk    (radio_clk),
    .radio_rst    (radio_rst),
    .i_ctrl_req   (i_ctrl_req),
    .o_ctrl_resp  (o_ctrl_resp),
    .o_cmd        (reg_cmd),
    .o_cmd_valid  (reg_cmd_valid),
    .i_cmd_ready  (cmd_ready),
    .i_cmd_space  (cmd_space),
    .o_cmd_stop   (cmd_stop),
    .i_stop_ack   (stop_ack),
    .o_fifo_clear (cmd_clear),
    .o_max_pkt_len(max_pkt_len),
    .o_has_time   (o_rx_has_time)
  );

  // ------------------------------
  // Command queue
  // ------------------------------
  rx_sync_fifo #(
    .WIDTH     ($bits(radio_rx_pkg::rx_cmd_t)),
    .DEPTH_LOG2(`RX_CMD_FIFO_LOG2)
  ) cmd_fifo_i (
    .radio_clk(radio_clk),
    .radio_rst(radio_rst),
    .i_clear  (cmd_clear),
    .i_data   (reg_cmd),
    .i_valid  (reg_cmd_valid),
    .o_ready  (cmd_ready),
    .o_data   (head_cmd),
    .o_valid  (head_valid),
    .i_ready  (cmd_pop),
    .o_space  (cmd_space)
  );

  // ------------------------------
  // Receiver FSM
  // ------------------------------
  radio_rx_fsm fsm_i (
    .radio_clk    (radio_clk),
    .radio_rst    (radio_rst),
    .i_cmd        (head_cmd),
    .i_cmd_valid  (head_valid),
    .o_cmd_pop    (cmd_pop),
    .i_cmd_stop   (cmd_stop),
    .o_stop_ack   (stop_ack),
    .i_max_pkt_len(max_pkt_len),
    .i_radio_time (i_radio_time),
    .i_radio_data (i_radio_data),
    .i_radio_stb  (i_radio_stb),
    .i_out_space  (out_space),
    .o_beat       (fsm_beat),
    .o_beat_push  (fsm_push),
    .o_rx_running (o_rx_running)
  );

  // ------------------------------
  // Output FIFO
  // ------------------------------
  // Almost-full margin in the FSM keeps pushes from ever being refused
  rx_sync_fifo #(
    .WIDTH     ($bits(radio_rx_pkg::rx_beat_t)),
    .DEPTH_LOG2(`RX_OUT_FIFO_LOG2)
  ) out_fifo_i (
    .radio_clk(radio_clk),
    .radio_rst(radio_rst),
    .i_clear  (1'b0),
    .i_data   (fsm_beat),
    .i_valid  (fsm_push),
    .o_ready  (),
    .o_data   (o_rx_beat),
    .o_valid  (o_rx_valid),
    .i_ready  (i_rx_ready),
    .o_space  (out_space)
  );

endmodule

//--- src/rx_sync_fifo.sv
// Synchronous circular-buffer FIFO
// Valid/ready on both sides, one-cycle clear and free-space count
`timescale 1ns/1ps

module rx_sync_fifo #(
  parameter int WIDTH      = 32,
  parameter int DEPTH_LOG2 = 4
) (
  input  logic                  radio_clk,
  input  logic                  radio_rst,
  input  logic                  i_clear,
  // Write side
  input  logic [WIDTH-1:0]      i_data,
  input  logic                  i_valid,
  output logic                  o_ready,
  // Read side
  output logic [WIDTH-1:0]      o_data,
  output logic                  o_valid,
  input  logic                  i_ready,
  // Free entries
  output logic [DEPTH_LOG2:0]   o_space
);

  localparam int DEPTH = 2 ** DEPTH_LOG2;
  localparam logic [DEPTH_LOG2:0] DEPTH_CNT = (DEPTH_LOG2 + 1)'(DEPTH);

  logic [WIDTH-1:0]      mem [DEPTH];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  // One extra bit so full and empty differ
  logic [DEPTH_LOG2:0]   count;
  logic                  push;
  logic                  pop;

  assign o_ready = (count != DEPTH_CNT);
  assign o_valid = (count != '0);
  assign o_space = DEPTH_CNT - count;
  assign push    = i_valid && o_ready;
  assign pop     = o_valid && i_ready;

  // Head entry straight from the storage registers
  assign o_data  = mem[rd_ptr];

  always_ff @(posedge radio_clk) begin
    if (push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge radio_clk) begin
    if (radio_rst || i_clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves count as is
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- verif/radio_rx_tb.sv
// Testbench of the receive core
// Control port tasks, reference beat model, stream checker and timeout
`timescale 1ns/1ps
`include "radio_rx_macros.svh"

module radio_rx_tb;

  // Limit well above the roughly 1,200 cycles the tests need
  localparam int          TIMEOUT_CYCLES = 20000;
  localparam logic [31:0] SEED           = 32'hd921986a;

  logic                     radio_clk  = 1'b0;
  logic                     radio_rst;
  radio_rx_pkg::ctrl_req_t  ctrl_req;
  radio_rx_pkg::ctrl_resp_t ctrl_resp;
  logic [63:0]              radio_time = '0;
  logic [31:0]              radio_data = '0;
  logic                     radio_stb;
  logic                     rx_running;
  radio_rx_pkg::rx_beat_t   rx_beat;
  logic                     rx_valid;
  logic                     rx_ready   = 1'b0;
  logic                     rx_has_time;

  // Ready mode 0 holds ready low, 1 holds it high and 2 adds random gaps
  int          ready_mode = 1;
  // Expected burst as set by the test sequence
  int          test_id = 0;
  string       test_name = "reset";
  bit          exp_cont;
  int          exp_words;
  int          exp_pkt = 64;
  bit          check_first;
  logic [31:0] exp_first;
  // Stream checker state
  int          cur_id = 0;
  int          beat_cnt = 0;
  bit          burst_done;
  bit          running_seen;
  logic [31:0] prev_data;
  logic [63:0] pkt_ts;
  int          stream_errors = 0;
  int          reg_errors = 0;

  radio_rx_core radio_rx_core_i (
    .radio_clk    (radio_clk),
    .radio_rst    (radio_rst),
    .i_ctrl_req   (ctrl_req),
    .o_ctrl_resp  (ctrl_resp),
    .i_radio_time (radio_time),
    .i_radio_data (radio_data),
    .i_radio_stb  (radio_stb),
    .o_rx_running (rx_running),
    .o_rx_beat    (rx_beat),
    .o_rx_valid   (rx_valid),
    .i_rx_ready   (rx_ready),
    .o_rx_has_time(rx_has_time)
  );

  always #20 radio_clk = ~radio_clk;

  // Free-running radio time with data naming the time it was taken at
  always @(posedge radio_clk) begin
    radio_time <= radio_time + 64'd1;
    radio_data <= radio_time[31:0] + 32'd1;
  end

  always @(posedge radio_clk) begin
    case (ready_mode)
      0:       rx_ready <= 1'b0;
      1:       rx_ready <= 1'b1;
      default: rx_ready <= ($urandom % 4) != 0;
    endcase
  end

  // ------------------------------
  // Reference model and compare
  // ------------------------------
  // Returns packet start, last and end-of-burst for beat idx (from 1)
  function automatic logic [2:0] ref_flags(input bit cont, input int words,
                                           input int pkt, input int idx);
    logic start;
    logic last;
    logic eob;
    start = ((idx - 1) % pkt) == 0;
    eob   = !cont && (idx == words);
    last  = eob || ((idx % pkt) == 0);
    return {start, last, eob};
  endfunction

  function automatic int check_value(input string what, input logic [63:0] exp_v,
                                     input logic [63:0] act_v);
    int bad;
    bad = 0;
    assert (exp_v == act_v) else begin
      $display("Error %s: %s expected %0h actual %0h", test_name, what, exp_v, act_v);
      bad = 1;
    end
    return bad;
  endfunction

  // Stream checker samples valid and ready at the falling edge
  always @(negedge radio_clk) begin : stream_check
    logic [2:0]  exp_flags;
    logic [63:0] exp_ts;
    if (test_id != cur_id) begin
      cur_id       = test_id;
      beat_cnt     = 0;
      burst_done   = 1'b0;
      running_seen = 1'b0;
    end
    if (rx_running) begin
      running_seen = 1'b1;
    end
    if (!radio_rst && rx_valid && rx_ready) begin
      beat_cnt++;
      exp_flags = ref_flags(exp_cont, exp_words, exp_pkt, beat_cnt);
      // Continuous burst ends on a stop or an overrun
      if (exp_cont && rx_beat.eob) begin
        exp_flags[1:0] = 2'b11;
      end
      exp_ts = exp_flags[2] ? {32'd0, rx_beat.data} : pkt_ts;
      assert (!burst_done) else begin
        stream_errors++;
        $display("%s: beat %0d arrived after the burst had ended", test_name, beat_cnt);
      end
      if (beat_cnt > 1) begin
        stream_errors += check_value("beat data", 64'(prev_data + 32'd1), 64'(rx_beat.data));
      end else if (check_first) begin
        stream_errors += check_value("first data", 64'(exp_first), 64'(rx_beat.data));
      end
      stream_errors += check_value("beat last", 64'(exp_flags[1]), 64'(rx_beat.last));
      stream_errors += check_value("beat eob", 64'(exp_flags[0]), 64'(rx_beat.eob));
      stream_errors += check_value("timestamp", exp_ts, rx_beat.timestamp);
      pkt_ts    = exp_ts;
      prev_data = rx_beat.data;
      if (rx_beat.eob) begin
        burst_done = 1'b1;
      end
    end
  end

  // ------------------------------
  // Control port tasks
  // ------------------------------
  task automatic ctrl_access(input logic wr, input logic [19:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    radio_rx_pkg::ctrl_req_t req;
    req.wr   = wr;
    req.rd   = !wr;
    req.addr = addr;
    req.data = wdata;
    @(posedge radio_clk);
    ctrl_req <= req;
    @(posedge radio_clk);
    ctrl_req <= '0;
    @(negedge radio_clk);
    while (!ctrl_resp.ack) begin
      @(negedge radio_clk);
    end
    rdata = ctrl_resp.data;
  endtask

  task automatic reg_write(input logic [19:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    ctrl_access(1'b1, addr, data, unused);
  endtask

  task automatic read_check(input string what, input logic [19:0] addr,
                            input logic [31:0] exp_v);
    logic [31:0] rdata;
    ctrl_access(1'b0, addr, 32'd0, rdata);
    reg_errors += check_value(what, 64'(exp_v), 64'(rdata));
  endtask

  task automatic issue_cmd(input logic [1:0] code, input logic timed,
                           input logic [63:0] words, input logic [63:0] t_cmd);
    reg_write(`RX_REG_NUM_WORDS_LO, words[31:0]);
    reg_write(`RX_REG_NUM_WORDS_HI, words[63:32]);
    reg_write(`RX_REG_TIME_LO, t_cmd[31:0]);
    reg_write(`RX_REG_TIME_HI, t_cmd[63:32]);
    reg_write(`RX_REG_CMD, {timed, 29'd0, code});
  endtask

  task automatic expect_burst(input string name, input bit cont, input int words,
                              input int pkt, input bit chk_first, input logic [31:0] first);
    test_name   = name;
    exp_cont    = cont;
    exp_words   = words;
    exp_pkt     = pkt;
    check_first = chk_first;
    exp_first   = first;
    test_id++;
    @(negedge radio_clk);
  endtask

  // Waits for the end of the burst and then for stray beats
  task automatic wait_burst();
    while (!burst_done) begin
      @(posedge radio_clk);
    end
    repeat (40) @(posedge radio_clk);
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    logic [63:0] t_cmd;
    int          delay;
    void'($urandom(SEED));
    radio_rst <= 1'b1;
    ctrl_req  <= '0;
    radio_stb <= 1'b1;
    repeat (8) @(posedge radio_clk);
    radio_rst <= 1'b0;
    repeat (2) @(negedge radio_clk);

    // Reset values and register readback
    expect_burst("registers", 0, 0, 64, 0, 32'd0);
    reg_errors += check_value("ack after reset", 64'd0, 64'(ctrl_resp.ack));
    reg_errors += check_value("o_rx_valid", 64'd0, 64'(rx_valid));
    reg_errors += check_value("o_rx_running", 64'd0, 64'(rx_running));
    read_check("max packet length", `RX_REG_MAX_WORDS_PER_PKT, 32'd64);
    read_check("has_time", `RX_REG_HAS_TIME, 32'd1);
    reg_errors += check_value("o_rx_has_time", 64'd1, 64'(rx_has_time));
    reg_write(`RX_REG_HAS_TIME, 32'd0);
    read_check("has_time", `RX_REG_HAS_TIME, 32'd0);
    reg_errors += check_value("o_rx_has_time", 64'd0, 64'(rx_has_time));
    reg_write(`RX_REG_HAS_TIME, 32'd1);
    reg_write(`RX_REG_MAX_WORDS_PER_PKT, 32'd100);
    read_check("max packet length", `RX_REG_MAX_WORDS_PER_PKT, 32'd100);
    reg_write(`RX_REG_NUM_WORDS_LO, 32'h1234_5678);
    read_check("num words lo", `RX_REG_NUM_WORDS_LO, 32'h1234_5678);
    reg_write(`RX_REG_NUM_WORDS_HI, 32'h0000_00a5);
    read_check("num words hi", `RX_REG_NUM_WORDS_HI, 32'h0000_00a5);
    reg_write(`RX_REG_TIME_LO, 32'h8765_4321);
    read_check("time lo", `RX_REG_TIME_LO, 32'h8765_4321);
    reg_write(`RX_REG_TIME_HI, 32'h0000_5a5a);
    read_check("time hi", `RX_REG_TIME_HI, 32'h0000_5a5a);
    read_check("unlisted address", 20'h20, 32'd0);
    read_check("status empty", `RX_REG_STATUS, 32'd16);
    // Timed far in the future so it waits at the head
    issue_cmd(`RX_CMD_FINITE, 1'b1, 64'd10, {32'd1, 32'd0});
    read_check("status one queued", `RX_REG_STATUS, 32'd15);
    reg_write(`RX_REG_CMD, {30'd0, `RX_CMD_STOP});
    repeat (5) @(posedge radio_clk);
    read_check("status after stop", `RX_REG_STATUS, 32'd16);

    // Finite untimed acquisition over three packets
    expect_burst("finite_untimed", 0, 150, 64, 0, 32'd0);
    reg_write(`RX_REG_MAX_WORDS_PER_PKT, 32'd64);
    issue_cmd(`RX_CMD_FINITE, 1'b0, 64'd150, 64'd0);
    wait_burst();
    reg_errors += check_value("beat count", 64'd150, 64'(beat_cnt));

    // Timed finite with random ready gaps
    t_cmd = radio_time + 64'd200;
    expect_burst("timed_finite", 0, 48, 20, 1, t_cmd[31:0]);
    ready_mode = 2;
    reg_write(`RX_REG_MAX_WORDS_PER_PKT, 32'd20);
    issue_cmd(`RX_CMD_FINITE, 1'b1, 64'd48, t_cmd);
    wait_burst();
    ready_mode = 1;
    reg_errors += check_value("beat count", 64'd48, 64'(beat_cnt));

    // Continuous acquisition ended by STOP after a random delay
    expect_burst("continuous_stop", 1, 0, 16, 0, 32'd0);
    reg_write(`RX_REG_MAX_WORDS_PER_PKT, 32'd16);
    issue_cmd(`RX_CMD_CONTINUOUS, 1'b0, 64'd0, 64'd0);
    while (!rx_running) begin
      @(posedge radio_clk);
    end
    delay = 50 + int'($urandom % 100);
    repeat (delay) @(posedge radio_clk);
    // Burst must still be open until the stop is written
    reg_errors += check_value("running before stop", 64'd1, 64'(rx_running));
    reg_errors += check_value("burst open before stop", 64'd0, 64'(burst_done));
    reg_write(`RX_REG_CMD, {30'd0, `RX_CMD_STOP});
    wait_burst();
    reg_errors += check_value("o_rx_running", 64'd0, 64'(rx_running));

    // Overrun with ready held low and a later drain
    expect_burst("overrun", 1, 0, 16, 0, 32'd0);
    ready_mode = 0;
    issue_cmd(`RX_CMD_CONTINUOUS, 1'b0, 64'd0, 64'd0);
    while (!rx_running) begin
      @(posedge radio_clk);
    end
    while (rx_running) begin
      @(posedge radio_clk);
    end
    repeat (10) @(posedge radio_clk);
    ready_mode = 1;
    wait_burst();
    // Burst closes only once free space drops below the margin
    assert (beat_cnt > 32 - `RX_ALMOST_FULL && beat_cnt <= 32) else begin
      reg_errors++;
      $display("Error overrun: drained beats expected %0d to 32 actual %0d",
               32 - `RX_ALMOST_FULL + 1, beat_cnt);
    end
    reg_errors += check_value("o_rx_running", 64'd0, 64'(rx_running));
    expect_burst("after_overrun", 0, 10, 16, 0, 32'd0);
    issue_cmd(`RX_CMD_FINITE, 1'b0, 64'd10, 64'd0);
    wait_burst();
    reg_errors += check_value("beat count", 64'd10, 64'(beat_cnt));

    // Late timed command is dropped without data
    expect_burst("late_timed", 0, 20, 16, 0, 32'd0);
    t_cmd = radio_time - 64'd10;
    issue_cmd(`RX_CMD_FINITE, 1'b1, 64'd20, t_cmd);
    repeat (30) @(posedge radio_clk);
    reg_errors += check_value("beat count", 64'd0, 64'(beat_cnt));
    reg_errors += check_value("running seen", 64'd0, 64'(running_seen));
    read_check("status after late", `RX_REG_STATUS, 32'd16);

    $display("Run finished, %0d register errors, %0d stream errors",
             reg_errors, stream_errors);
    if (reg_errors + stream_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Cycle limit on the whole run
  initial begin
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge radio_clk);
      cycles++;
    end
    $display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TB FAILED");
    $finish;
  end

endmodule
